// ==== verilog/csrPkg.sv ====
package csrPkg;

	// machine-mode CSR map
	typedef enum logic [11:0] {
		MSTATUS = 12'h300,
		MIE = 12'h304,
		MTVEC = 12'h305,
		MSCRATCH = 12'h340,
		MEPC = 12'h341,
		MCAUSE = 12'h342,
		MTVAL = 12'h343,
		MIP = 12'h344,
		MCYCLE = 12'hB00,
		MINSTRET = 12'hB02,
		MCYCLEH = 12'hB80,
		MINSTRETH = 12'hB82
	} csrAddr_e;

	typedef enum logic [30:0] {
		FETCH_MISALIGNED = 31'd0,
		FETCH_FAULT = 31'd1,
		ILLEGAL = 31'd2,
		BREAKPOINT = 31'd3,
		LOAD_MISALIGNED = 31'd4,
		LOAD_FAULT = 31'd5,
		STORE_MISALIGNED = 31'd6,
		STORE_FAULT = 31'd7,
		ECALL_M = 31'd11
	} exceptionCause_e;

	typedef enum logic [30:0] {
		SOFTWARE = 31'd3,
		TIMER = 31'd7,
		USER = 31'd8,
		EXTERNAL = 31'd11
	} interruptCause_e;

	// single-cycle CSR port, one address per direction
	typedef struct packed {
		logic writeEnable;
		logic readEnable;
		logic [11:0] writeAddress;
		logic [11:0] readAddress;
		logic [31:0] writeData;
	} csrBus_t;

	typedef struct packed {
		logic softwareInterrupt;
		logic timerInterrupt;
		logic externalInterrupt;
		logic [15:0] userInterrupts;
		logic fetchMisaligned;
		logic jumpMisaligned;
		logic fetchFault;
		logic illegalInstruction;
		logic ebreak;
		logic ecall;
		logic fetchBreakpoint;
		logic dataBreakpoint;
		logic loadMisaligned;
		logic storeMisaligned;
		logic loadFault;
		logic storeFault;
	} trapEvents_t;

	typedef struct packed {
		logic [31:0] programCounter;
		logic [31:0] instruction;
		logic [31:0] fetchAddress;
		logic [31:0] dataAddress;
	} trapAddresses_t;

	// interrupt lines laid out as in mip/mie
	function automatic logic [31:0] interruptVector(input trapEvents_t events);
		return {events.userInterrupts, 4'b0000,
			events.externalInterrupt, 3'b000,
			events.timerInterrupt, 3'b000,
			events.softwareInterrupt, 3'b000};
	endfunction

endpackage

// ==== verilog/csrDataRegister.sv ====
`timescale 1ns/1ps

module csrDataRegister #(
	parameter logic [11:0] ADDRESS = 12'h000
) (
	input logic clk,
	input logic rst,
	input csrPkg::csrBus_t csrBus,
	input logic [31:0] ownerValue,
	output logic [31:0] readData,
	output logic requestOutput,
	output logic [31:0] writeData,
	output logic writeStrobe
);

	// storage sits in the owner, so only decode here
	assign requestOutput = csrBus.readEnable && (csrBus.readAddress == ADDRESS);

	// zero when not selected so owners can OR responses together
	assign readData = requestOutput ? ownerValue : 32'h0000_0000;

	assign writeStrobe = csrBus.writeEnable && (csrBus.writeAddress == ADDRESS);
	assign writeData = csrBus.writeData;

endmodule

// ==== verilog/csrConfigurationRegister.sv ====
`timescale 1ns/1ps

module csrConfigurationRegister #(
	parameter logic [11:0] ADDRESS = 12'h000,
	parameter logic [31:0] DEFAULT = 32'h0000_0000
) (
	input logic clk,
	input logic rst,
	input csrPkg::csrBus_t csrBus,
	output logic [31:0] readData,
	output logic requestOutput,
	output logic [31:0] value
);
	logic writeMatch;

	assign writeMatch = csrBus.writeEnable && (csrBus.writeAddress == ADDRESS);
	assign requestOutput = csrBus.readEnable && (csrBus.readAddress == ADDRESS);
	assign readData = requestOutput ? value : 32'h0000_0000;

	always_ff @(posedge clk) begin
		if (rst) begin
			value <= DEFAULT;
		end else if (writeMatch) begin
			value <= csrBus.writeData;
		end
	end

endmodule

// ==== verilog/trapCauseEncoder.sv ====
`timescale 1ns/1ps

module trapCauseEncoder (
	input csrPkg::trapEvents_t events,
	input csrPkg::trapAddresses_t addresses,
	input logic [31:0] enabledInterrupts,
	output logic isInterrupt,
	output logic isTrap,
	output logic [30:0] cause,
	output logic [31:0] trapValue
);
	logic [31:0] pendingInterrupts;
	logic isException;

	assign pendingInterrupts = csrPkg::interruptVector(events) & enabledInterrupts;
	assign isInterrupt = |pendingInterrupts;

	assign isException = events.fetchMisaligned || events.jumpMisaligned
		|| events.fetchFault || events.illegalInstruction
		|| events.ebreak || events.ecall
		|| events.fetchBreakpoint || events.dataBreakpoint
		|| events.loadMisaligned || events.storeMisaligned
		|| events.loadFault || events.storeFault;

	// interrupts outrank every exception
	assign isTrap = isInterrupt || isException;

	always_comb begin
		cause = 31'd0;
		trapValue = 32'h0000_0000;
		if (isInterrupt) begin
			if (pendingInterrupts[3])
				cause = csrPkg::SOFTWARE;
			else if (pendingInterrupts[7])
				cause = csrPkg::TIMER;
			else if (|pendingInterrupts[31:16])
				cause = csrPkg::USER;
			else
				cause = csrPkg::EXTERNAL;
		end else if (events.fetchBreakpoint) begin
			cause = csrPkg::BREAKPOINT;
			trapValue = addresses.programCounter;
		end else if (events.fetchFault) begin
			cause = csrPkg::FETCH_FAULT;
		end else if (events.illegalInstruction) begin
			cause = csrPkg::ILLEGAL;
			trapValue = addresses.instruction;
		end else if (events.fetchMisaligned || events.jumpMisaligned) begin
			// cause code is zero here, isException still flags the trap
			cause = csrPkg::FETCH_MISALIGNED;
			trapValue = addresses.fetchAddress;
		end else if (events.ecall) begin
			cause = csrPkg::ECALL_M;
		end else if (events.ebreak || events.dataBreakpoint) begin
			cause = csrPkg::BREAKPOINT;
			trapValue = addresses.programCounter;
		end else if (events.storeMisaligned) begin
			cause = csrPkg::STORE_MISALIGNED;
			trapValue = addresses.dataAddress;
		end else if (events.loadMisaligned) begin
			cause = csrPkg::LOAD_MISALIGNED;
			trapValue = addresses.dataAddress;
		end else if (events.storeFault) begin
			cause = csrPkg::STORE_FAULT;
		end else if (events.loadFault) begin
			cause = csrPkg::LOAD_FAULT;
		end
	end

endmodule

// ==== verilog/traps.sv ====
`timescale 1ns/1ps

module traps #(
	parameter logic [31:0] MTVEC_RESET = 32'h0000_0000
) (
	input logic clk,
	input logic rst,
	input csrPkg::csrBus_t csrBus,
	input csrPkg::trapEvents_t events,
	input csrPkg::trapAddresses_t addresses,
	input logic trapReturn,
	output logic [31:0] readData,
	output logic requestOutput,
	output logic inTrap,
	output logic [31:0] trapVector,
	output logic [31:0] trapReturnVector
);
	logic machineInterruptEnable;
	logic previousInterruptEnable;
	logic [31:0] mieValue;
	logic [31:0] mtvecValue;
	logic [31:0] mepcValue;
	logic [31:0] mepcVisible;
	logic [31:0] mcauseValue;
	logic [31:0] mtvalValue;
	logic [31:0] mipValue;
	logic isInterrupt;
	logic [30:0] cause;
	logic [31:0] trapValue;
	logic [31:0] trapBase;
	// 0 mstatus, 1 mie, 2 mtvec, 3 mscratch, 4 mepc, 5 mcause, 6 mtval, 7 mip
	logic [7:0] regRequest;
	logic [31:0] regReadData [8];
	logic [31:0] mstatusWriteData;
	logic [31:0] mtvecWriteData;
	logic [31:0] mepcWriteData;
	logic [31:0] mcauseWriteData;
	logic [31:0] mtvalWriteData;
	logic [31:0] mipWriteData;
	logic mstatusStrobe;
	logic mtvecStrobe;
	logic mepcStrobe;
	logic mcauseStrobe;
	logic mtvalStrobe;
	logic mipStrobe;

	trapCauseEncoder causeEncoder (
		.events(events), .addresses(addresses), .enabledInterrupts(mieValue),
		.isInterrupt(isInterrupt), .isTrap(inTrap),
		.cause(cause), .trapValue(trapValue));

	csrDataRegister #(.ADDRESS(csrPkg::MSTATUS)) mstatusReg (
		.clk(clk), .rst(rst), .csrBus(csrBus),
		.ownerValue({24'b0, previousInterruptEnable, 3'b000, machineInterruptEnable, 3'b000}),
		.readData(regReadData[0]), .requestOutput(regRequest[0]),
		.writeData(mstatusWriteData), .writeStrobe(mstatusStrobe));

	csrConfigurationRegister #(.ADDRESS(csrPkg::MIE), .DEFAULT(32'h0000_0000)) mieReg (
		.clk(clk), .rst(rst), .csrBus(csrBus),
		.readData(regReadData[1]), .requestOutput(regRequest[1]), .value(mieValue));

	csrDataRegister #(.ADDRESS(csrPkg::MTVEC)) mtvecReg (
		.clk(clk), .rst(rst), .csrBus(csrBus), .ownerValue(mtvecValue),
		.readData(regReadData[2]), .requestOutput(regRequest[2]),
		.writeData(mtvecWriteData), .writeStrobe(mtvecStrobe));

	csrConfigurationRegister #(.ADDRESS(csrPkg::MSCRATCH), .DEFAULT(32'h0000_0000)) mscratchReg (
		.clk(clk), .rst(rst), .csrBus(csrBus),
		.readData(regReadData[3]), .requestOutput(regRequest[3]), .value());

	csrDataRegister #(.ADDRESS(csrPkg::MEPC)) mepcReg (
		.clk(clk), .rst(rst), .csrBus(csrBus), .ownerValue(mepcVisible),
		.readData(regReadData[4]), .requestOutput(regRequest[4]),
		.writeData(mepcWriteData), .writeStrobe(mepcStrobe));

	csrDataRegister #(.ADDRESS(csrPkg::MCAUSE)) mcauseReg (
		.clk(clk), .rst(rst), .csrBus(csrBus), .ownerValue(mcauseValue),
		.readData(regReadData[5]), .requestOutput(regRequest[5]),
		.writeData(mcauseWriteData), .writeStrobe(mcauseStrobe));

	csrDataRegister #(.ADDRESS(csrPkg::MTVAL)) mtvalReg (
		.clk(clk), .rst(rst), .csrBus(csrBus), .ownerValue(mtvalValue),
		.readData(regReadData[6]), .requestOutput(regRequest[6]),
		.writeData(mtvalWriteData), .writeStrobe(mtvalStrobe));

	csrDataRegister #(.ADDRESS(csrPkg::MIP)) mipReg (
		.clk(clk), .rst(rst), .csrBus(csrBus), .ownerValue(mipValue),
		.readData(regReadData[7]), .requestOutput(regRequest[7]),
		.writeData(mipWriteData), .writeStrobe(mipStrobe));

	// vectored mode only applies to interrupts
	assign trapBase = {mtvecValue[31:2], 2'b00};
	assign trapVector = (mtvecValue[1:0] == 2'b01 && isInterrupt)
		? trapBase + {cause[29:0], 2'b00} : trapBase;

	assign mepcVisible = {mepcValue[31:1], 1'b0};
	assign trapReturnVector = mepcVisible;

	always_ff @(posedge clk) begin
		if (rst) begin
			machineInterruptEnable <= 1'b0;
			previousInterruptEnable <= 1'b0;
			mtvecValue <= MTVEC_RESET;
			mepcValue <= '0;
			mcauseValue <= '0;
			mtvalValue <= '0;
			mipValue <= '0;
		end else begin
			// MIE/MPIE stack, return wins over trap, trap over software write
			if (trapReturn) begin
				machineInterruptEnable <= previousInterruptEnable;
				previousInterruptEnable <= 1'b0;
			end else if (inTrap) begin
				previousInterruptEnable <= machineInterruptEnable;
				machineInterruptEnable <= 1'b0;
			end else if (mstatusStrobe) begin
				machineInterruptEnable <= mstatusWriteData[3];
				previousInterruptEnable <= mstatusWriteData[7];
			end
			// only modes 0 and 1 exist
			if (mtvecStrobe)
				mtvecValue <= {mtvecWriteData[31:2], 1'b0, mtvecWriteData[0]};
			if (inTrap) begin
				mepcValue <= addresses.programCounter;
				mcauseValue <= {isInterrupt, cause};
				mtvalValue <= trapValue;
				mipValue <= csrPkg::interruptVector(events) & mieValue;
			end else begin
				if (mepcStrobe)
					mepcValue <= mepcWriteData;
				if (mcauseStrobe)
					mcauseValue <= mcauseWriteData;
				if (mtvalStrobe)
					mtvalValue <= mtvalWriteData;
				if (mipStrobe)
					mipValue <= mipWriteData;
			end
		end
	end

	// unselected registers return zero
	always_comb begin
		readData = '0;
		for (int i = 0; i < 8; i++) begin
			readData = readData | regReadData[i];
		end
	end

	assign requestOutput = |regRequest;

endmodule

// ==== verilog/machineCounters.sv ====
`timescale 1ns/1ps

module machineCounters (
	input logic clk,
	input logic rst,
	input csrPkg::csrBus_t csrBus,
	input logic instructionRetired,
	output logic [31:0] readData,
	output logic requestOutput
);
	logic [63:0] count [2];
	logic [1:0] increment;
	logic [3:0] halfRequest;
	logic [31:0] halfData [4];

	// index 0 is mcycle, index 1 is minstret
	assign increment = {instructionRetired, 1'b1};

	for (genvar i = 0; i < 2; i++) begin : counterGen
		localparam logic [11:0] LOW_ADDRESS = (i == 0) ? csrPkg::MCYCLE : csrPkg::MINSTRET;
		localparam logic [11:0] HIGH_ADDRESS = (i == 0) ? csrPkg::MCYCLEH : csrPkg::MINSTRETH;
		logic [63:0] nextCount;
		logic [31:0] lowWriteData;
		logic [31:0] highWriteData;
		logic lowStrobe;
		logic highStrobe;

		csrDataRegister #(.ADDRESS(LOW_ADDRESS)) lowHalf (
			.clk(clk), .rst(rst), .csrBus(csrBus), .ownerValue(count[i][31:0]),
			.readData(halfData[2 * i]), .requestOutput(halfRequest[2 * i]),
			.writeData(lowWriteData), .writeStrobe(lowStrobe));

		csrDataRegister #(.ADDRESS(HIGH_ADDRESS)) highHalf (
			.clk(clk), .rst(rst), .csrBus(csrBus), .ownerValue(count[i][63:32]),
			.readData(halfData[2 * i + 1]), .requestOutput(halfRequest[2 * i + 1]),
			.writeData(highWriteData), .writeStrobe(highStrobe));

		assign nextCount = count[i] + {63'd0, increment[i]};

		// a low-half write still lets the carry reach the high half
		always_ff @(posedge clk) begin
			if (rst) begin
				count[i] <= '0;
			end else begin
				count[i][31:0] <= lowStrobe ? lowWriteData : nextCount[31:0];
				count[i][63:32] <= highStrobe ? highWriteData : nextCount[63:32];
			end
		end
	end

	assign readData = halfData[0] | halfData[1] | halfData[2] | halfData[3];
	assign requestOutput = |halfRequest;

endmodule

// ==== verilog/csrUnit.sv ====
`timescale 1ns/1ps

module csrUnit #(
	parameter logic [31:0] MTVEC_RESET = 32'h0000_0000
) (
	input logic clk,
	input logic rst,
	input csrPkg::csrBus_t csrBus,
	input csrPkg::trapEvents_t events,
	input csrPkg::trapAddresses_t addresses,
	input logic trapReturn,
	input logic instructionRetired,
	output logic [31:0] readData,
	output logic requestOutput,
	output logic inTrap,
	output logic [31:0] trapVector,
	output logic [31:0] trapReturnVector
);
	logic [31:0] trapsReadData;
	logic [31:0] countersReadData;
	logic trapsRequest;
	logic countersRequest;

	traps #(.MTVEC_RESET(MTVEC_RESET)) trapBlock (
		.clk(clk),
		.rst(rst),
		.csrBus(csrBus),
		.events(events),
		.addresses(addresses),
		.trapReturn(trapReturn),
		.readData(trapsReadData),
		.requestOutput(trapsRequest),
		.inTrap(inTrap),
		.trapVector(trapVector),
		.trapReturnVector(trapReturnVector));

	machineCounters counterBlock (
		.clk(clk),
		.rst(rst),
		.csrBus(csrBus),
		.instructionRetired(instructionRetired),
		.readData(countersReadData),
		.requestOutput(countersRequest));

	// counters return zero unless they claim the address
	assign requestOutput = trapsRequest | countersRequest;
	assign readData = trapsRequest ? trapsReadData : countersReadData;

endmodule

// ==== testbench/csrUnitTb.sv ====
`timescale 1ns/1ps

module csrUnitTb #(
	parameter int SEED = 79
);
	localparam logic [31:0] MTVEC_RESET = 32'h0000_0100;
	localparam int ITERATIONS = 40;
	localparam int COUNTER_CYCLES = 300;
	// 18 cycles per iteration over the CSR, trap and unmapped tests
	localparam int CYCLE_LIMIT = 6 + ITERATIONS * 18 + COUNTER_CYCLES + 100;

	logic clk = 1'b0;
	logic rst;
	csrPkg::csrBus_t csrBus;
	csrPkg::trapEvents_t events;
	csrPkg::trapAddresses_t addresses;
	logic trapReturn;
	logic instructionRetired;
	logic [31:0] readData;
	logic requestOutput;
	logic inTrap;
	logic [31:0] trapVector;
	logic [31:0] trapReturnVector;

	// reference model state
	logic globalEnable;
	logic previousEnable;
	logic [31:0] modelMie;
	logic [31:0] modelMtvec;
	logic [31:0] modelMscratch;
	logic [31:0] modelMepc;
	logic [31:0] modelMcause;
	logic [31:0] modelMtval;
	logic [31:0] modelMip;
	logic [63:0] modelCycle;
	logic [63:0] modelRetired;
	int passCount = 0;
	int failCount = 0;
	int cycleCount = 0;

	csrUnit #(.MTVEC_RESET(MTVEC_RESET)) i_csrUnit (
		.clk(clk),
		.rst(rst),
		.csrBus(csrBus),
		.events(events),
		.addresses(addresses),
		.trapReturn(trapReturn),
		.instructionRetired(instructionRetired),
		.readData(readData),
		.requestOutput(requestOutput),
		.inTrap(inTrap),
		.trapVector(trapVector),
		.trapReturnVector(trapReturnVector));

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT) begin
			$display("timeout: the run went past %0d clock cycles", CYCLE_LIMIT);
			$display("*** FAILED ***");
			$finish;
		end
	end

	always @(posedge clk) begin
		advanceModel();
	end

	function automatic logic [31:0] interruptBits(input csrPkg::trapEvents_t ev);
		logic [31:0] v;
		v = 32'h0;
		v[3] = ev.softwareInterrupt;
		v[7] = ev.timerInterrupt;
		v[11] = ev.externalInterrupt;
		v[31:16] = ev.userInterrupts;
		return v;
	endfunction

	function automatic logic mappedAddress(input logic [11:0] address);
		case (address)
			csrPkg::MSTATUS, csrPkg::MIE, csrPkg::MTVEC, csrPkg::MSCRATCH,
			csrPkg::MEPC, csrPkg::MCAUSE, csrPkg::MTVAL, csrPkg::MIP,
			csrPkg::MCYCLE, csrPkg::MCYCLEH, csrPkg::MINSTRET, csrPkg::MINSTRETH:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	// interrupts first, then exceptions in priority order
	task automatic classifyTrap(input csrPkg::trapEvents_t ev, input csrPkg::trapAddresses_t addr,
			output logic isInt, output logic isTrap, output logic [30:0] cause,
			output logic [31:0] tval);
		logic [31:0] pending;
		pending = interruptBits(ev) & modelMie;
		isInt = (pending != 32'h0);
		isTrap = isInt || (ev[11:0] != 12'h000);
		cause = 31'd0;
		tval = 32'h0;
		if (isInt) begin
			if (pending[3])
				cause = csrPkg::SOFTWARE;
			else if (pending[7])
				cause = csrPkg::TIMER;
			else if (pending[31:16] != 16'h0)
				cause = csrPkg::USER;
			else
				cause = csrPkg::EXTERNAL;
		end else if (ev.fetchBreakpoint) begin
			cause = csrPkg::BREAKPOINT;
			tval = addr.programCounter;
		end else if (ev.fetchFault) begin
			cause = csrPkg::FETCH_FAULT;
		end else if (ev.illegalInstruction) begin
			cause = csrPkg::ILLEGAL;
			tval = addr.instruction;
		end else if (ev.fetchMisaligned || ev.jumpMisaligned) begin
			cause = csrPkg::FETCH_MISALIGNED;
			tval = addr.fetchAddress;
		end else if (ev.ecall) begin
			cause = csrPkg::ECALL_M;
		end else if (ev.ebreak || ev.dataBreakpoint) begin
			cause = csrPkg::BREAKPOINT;
			tval = addr.programCounter;
		end else if (ev.storeMisaligned) begin
			cause = csrPkg::STORE_MISALIGNED;
			tval = addr.dataAddress;
		end else if (ev.loadMisaligned) begin
			cause = csrPkg::LOAD_MISALIGNED;
			tval = addr.dataAddress;
		end else if (ev.storeFault) begin
			cause = csrPkg::STORE_FAULT;
		end else if (ev.loadFault) begin
			cause = csrPkg::LOAD_FAULT;
		end
	endtask

	task automatic advanceModel();
		logic isInt;
		logic isTrap;
		logic [30:0] cause;
		logic [31:0] tval;
		logic [31:0] pending;
		logic [63:0] nextCycle;
		logic [63:0] nextRetired;
		logic wr;
		logic [11:0] wa;
		logic [31:0] wd;
		if (rst) begin
			globalEnable = 1'b0;
			previousEnable = 1'b0;
			modelMie = 32'h0;
			modelMtvec = MTVEC_RESET;
			modelMscratch = 32'h0;
			modelMepc = 32'h0;
			modelMcause = 32'h0;
			modelMtval = 32'h0;
			modelMip = 32'h0;
			modelCycle = 64'h0;
			modelRetired = 64'h0;
		end else begin
			// everything below is judged on the state before this edge
			classifyTrap(events, addresses, isInt, isTrap, cause, tval);
			pending = interruptBits(events) & modelMie;
			wr = csrBus.writeEnable;
			wa = csrBus.writeAddress;
			wd = csrBus.writeData;
			nextCycle = modelCycle + 64'd1;
			nextRetired = modelRetired + {63'd0, instructionRetired};
			if (wr && wa == csrPkg::MCYCLE)
				nextCycle[31:0] = wd;
			if (wr && wa == csrPkg::MCYCLEH)
				nextCycle[63:32] = wd;
			if (wr && wa == csrPkg::MINSTRET)
				nextRetired[31:0] = wd;
			if (wr && wa == csrPkg::MINSTRETH)
				nextRetired[63:32] = wd;
			modelCycle = nextCycle;
			modelRetired = nextRetired;
			if (trapReturn) begin
				globalEnable = previousEnable;
				previousEnable = 1'b0;
			end else if (isTrap) begin
				previousEnable = globalEnable;
				globalEnable = 1'b0;
			end else if (wr && wa == csrPkg::MSTATUS) begin
				globalEnable = wd[3];
				previousEnable = wd[7];
			end
			if (wr && wa == csrPkg::MIE)
				modelMie = wd;
			if (wr && wa == csrPkg::MSCRATCH)
				modelMscratch = wd;
			if (wr && wa == csrPkg::MTVEC)
				modelMtvec = wd & 32'hFFFF_FFFD;
			if (isTrap) begin
				modelMepc = addresses.programCounter;
				modelMcause = {isInt, cause};
				modelMtval = tval;
				modelMip = pending;
			end else begin
				if (wr && wa == csrPkg::MEPC)
					modelMepc = wd;
				if (wr && wa == csrPkg::MCAUSE)
					modelMcause = wd;
				if (wr && wa == csrPkg::MTVAL)
					modelMtval = wd;
				if (wr && wa == csrPkg::MIP)
					modelMip = wd;
			end
		end
	endtask

	task automatic readModel(input csrPkg::csrBus_t bus, output logic hit,
			output logic [31:0] data);
		hit = bus.readEnable && mappedAddress(bus.readAddress);
		data = 32'h0;
		if (hit) begin
			case (bus.readAddress)
				csrPkg::MSTATUS: data = {24'h0, previousEnable, 3'b000, globalEnable, 3'b000};
				csrPkg::MIE: data = modelMie;
				csrPkg::MTVEC: data = modelMtvec;
				csrPkg::MSCRATCH: data = modelMscratch;
				csrPkg::MEPC: data = modelMepc & 32'hFFFF_FFFE;
				csrPkg::MCAUSE: data = modelMcause;
				csrPkg::MTVAL: data = modelMtval;
				csrPkg::MIP: data = modelMip;
				csrPkg::MCYCLE: data = modelCycle[31:0];
				csrPkg::MCYCLEH: data = modelCycle[63:32];
				csrPkg::MINSTRET: data = modelRetired[31:0];
				csrPkg::MINSTRETH: data = modelRetired[63:32];
				default: data = 32'h0;
			endcase
		end
	endtask

	task automatic compareValue(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("[FAIL] time %0t %s expected %h actual %h", $time, name, expected, actual);
			failCount++;
		end else begin
			passCount++;
		end
	endtask

	task automatic checkOutputs();
		logic isInt;
		logic isTrap;
		logic [30:0] cause;
		logic [31:0] tval;
		logic [31:0] base;
		logic [31:0] vector;
		logic hit;
		logic [31:0] data;
		classifyTrap(events, addresses, isInt, isTrap, cause, tval);
		base = modelMtvec & 32'hFFFF_FFFC;
		vector = (modelMtvec[1:0] == 2'b01 && isInt) ? base + ({1'b0, cause} << 2) : base;
		readModel(csrBus, hit, data);
		compareValue("readData", data, readData);
		compareValue("requestOutput", {31'h0, hit}, {31'h0, requestOutput});
		compareValue("inTrap", {31'h0, isTrap}, {31'h0, inTrap});
		compareValue("trapVector", vector, trapVector);
		compareValue("trapReturnVector", modelMepc & 32'hFFFF_FFFE, trapReturnVector);
	endtask

	// drive on the rising edge, check at the falling edge
	task automatic runCycle(input csrPkg::csrBus_t bus, input csrPkg::trapEvents_t ev,
			input csrPkg::trapAddresses_t addr, input logic ret, input logic retired);
		@(posedge clk);
		csrBus <= bus;
		events <= ev;
		addresses <= addr;
		trapReturn <= ret;
		instructionRetired <= retired;
		@(negedge clk);
		checkOutputs();
	endtask

	task automatic writeCsr(input logic [11:0] address, input logic [31:0] data);
		csrPkg::csrBus_t bus;
		bus = '0;
		bus.writeEnable = 1'b1;
		bus.writeAddress = address;
		bus.writeData = data;
		runCycle(bus, '0, '0, 1'b0, 1'b0);
	endtask

	task automatic readCsr(input logic [11:0] address);
		csrPkg::csrBus_t bus;
		bus = '0;
		bus.readEnable = 1'b1;
		bus.readAddress = address;
		runCycle(bus, '0, '0, 1'b0, 1'b0);
	endtask

	function automatic logic [11:0] testedRegister(input int k);
		case (k)
			0: return csrPkg::MSCRATCH;
			1: return csrPkg::MIE;
			2: return csrPkg::MTVEC;
			3: return csrPkg::MEPC;
			default: return csrPkg::MCAUSE;
		endcase
	endfunction

	function automatic logic [11:0] counterAddress(input logic [1:0] k);
		case (k)
			2'd0: return csrPkg::MCYCLE;
			2'd1: return csrPkg::MCYCLEH;
			2'd2: return csrPkg::MINSTRET;
			default: return csrPkg::MINSTRETH;
		endcase
	endfunction

	// half single flags, half sparse mixes
	function automatic logic [11:0] randomExceptions();
		logic [31:0] r;
		int k;
		r = $urandom;
		k = int'($urandom % 12);
		if (r[0])
			return 12'h001 << k;
		return r[19:8] & r[31:20];
	endfunction

	function automatic csrPkg::trapEvents_t randomInterrupts();
		csrPkg::trapEvents_t ev;
		logic [31:0] r;
		ev = '0;
		r = $urandom;
		ev.softwareInterrupt = r[0];
		ev.timerInterrupt = r[1];
		ev.externalInterrupt = r[2];
		ev.userInterrupts = (r[5:3] == 3'd0) ? r[31:16] : 16'h0;
		return ev;
	endfunction

	function automatic logic [31:0] randomEnables();
		logic [31:0] r;
		r = $urandom;
		if (r[1:0] == 2'd0)
			return 32'hFFFF_0888;
		return r & 32'hFFFF_0888;
	endfunction

	function automatic csrPkg::trapAddresses_t randomAddresses();
		csrPkg::trapAddresses_t a;
		a.programCounter = $urandom;
		a.instruction = $urandom;
		a.fetchAddress = $urandom;
		a.dataAddress = $urandom;
		return a;
	endfunction

	task automatic reportTest(input string name, input int errorsBefore);
		$display("test %s finished with %0d mismatches", name, failCount - errorsBefore);
	endtask

	initial begin
		int errorsBefore;
		logic [31:0] r;
		logic [11:0] address;
		csrPkg::csrBus_t bus;
		csrPkg::trapEvents_t ev;
		csrPkg::trapAddresses_t trapAddr;
		logic [31:0] enables;
		logic [31:0] returnAddress;
		void'($urandom(SEED));
		rst <= 1'b1;
		csrBus <= '0;
		events <= '0;
		addresses <= '0;
		trapReturn <= 1'b0;
		instructionRetired <= 1'b0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;

		errorsBefore = failCount;
		for (int i = 0; i < ITERATIONS; i++) begin
			address = testedRegister(int'($urandom % 5));
			writeCsr(address, $urandom);
			readCsr(address);
			compareValue("requestOutput", 32'h1, {31'h0, requestOutput});
		end
		reportTest("csr write and read back", errorsBefore);

		errorsBefore = failCount;
		writeCsr(csrPkg::MIE, 32'h0);
		for (int i = 0; i < ITERATIONS; i++) begin
			ev = '0;
			ev[11:0] = randomExceptions();
			runCycle('0, ev, randomAddresses(), 1'b0, 1'b0);
			compareValue("inTrap", {31'h0, |ev[11:0]}, {31'h0, inTrap});
			readCsr(csrPkg::MCAUSE);
			readCsr(csrPkg::MEPC);
			readCsr(csrPkg::MTVAL);
		end
		reportTest("exception priority", errorsBefore);

		errorsBefore = failCount;
		for (int i = 0; i < ITERATIONS; i++) begin
			writeCsr(csrPkg::MSTATUS, 32'h0000_0008);
			enables = randomEnables();
			writeCsr(csrPkg::MIE, enables);
			ev = randomInterrupts();
			trapAddr = randomAddresses();
			// the return address only moves when an enabled interrupt traps
			if ((interruptBits(ev) & enables) != 32'h0)
				returnAddress = trapAddr.programCounter & 32'hFFFF_FFFE;
			else
				returnAddress = modelMepc & 32'hFFFF_FFFE;
			runCycle('0, ev, trapAddr, 1'b0, 1'b0);
			readCsr(csrPkg::MSTATUS);
			readCsr(csrPkg::MCAUSE);
			readCsr(csrPkg::MIP);
			bus = '0;
			bus.readEnable = 1'b1;
			bus.readAddress = csrPkg::MEPC;
			runCycle(bus, '0, '0, 1'b1, 1'b0);
			compareValue("readData", returnAddress, readData);
			compareValue("trapReturnVector", returnAddress, trapReturnVector);
			readCsr(csrPkg::MSTATUS);
		end
		reportTest("interrupt enable and return", errorsBefore);

		errorsBefore = failCount;
		for (int i = 0; i < ITERATIONS; i++) begin
			writeCsr(csrPkg::MTVEC, $urandom);
			writeCsr(csrPkg::MIE, randomEnables());
			ev = randomInterrupts();
			r = $urandom;
			if (r[0])
				ev[11:0] = randomExceptions();
			runCycle('0, ev, randomAddresses(), 1'b0, 1'b0);
		end
		reportTest("trap vector", errorsBefore);

		errorsBefore = failCount;
		for (int i = 0; i < COUNTER_CYCLES; i++) begin
			r = $urandom;
			bus = '0;
			bus.readEnable = 1'b1;
			bus.readAddress = counterAddress(r[1:0]);
			if (r[6:4] == 3'd0) begin
				// near the top of a low half, so the carry gets exercised
				bus.writeEnable = 1'b1;
				bus.writeAddress = counterAddress(r[9:8]);
				bus.writeData = r[10] ? 32'hFFFF_FFF8 : $urandom;
			end
			runCycle(bus, '0, '0, 1'b0, r[12]);
		end
		reportTest("cycle and retire counters", errorsBefore);

		errorsBefore = failCount;
		for (int i = 0; i < ITERATIONS; i++) begin
			r = $urandom;
			address = r[11:0];
			while (mappedAddress(address)) begin
				r = $urandom;
				address = r[11:0];
			end
			readCsr(address);
			compareValue("readData", 32'h0, readData);
			compareValue("requestOutput", 32'h0, {31'h0, requestOutput});
		end
		reportTest("unmapped addresses", errorsBefore);

		$display("checks: %0d passed, %0d failed", passCount, failCount);
		if (failCount == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
verilog/csrPkg.sv
verilog/csrDataRegister.sv
verilog/csrConfigurationRegister.sv
verilog/trapCauseEncoder.sv
verilog/traps.sv
verilog/machineCounters.sv
verilog/csrUnit.sv
testbench/csrUnitTb.sv

// ==== Makefile ====
TOP ?= csrUnitTb
SEED ?= 79
VERILATOR ?= verilator
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
PASS_TEXT = *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing -j 0 -f $(FLIST) --top-module $(TOP) \
		-GSEED=$(SEED) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qF '$(PASS_TEXT)'

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
